//--- design/rom_ctrl_pkg.sv
// ----------------------------------------
// ROM controller widths, multi-bit select,
// address map and ROM content functions
// ----------------------------------------
package rom_ctrl_pkg;

  parameter int RomAw = 6;
  parameter int RomDw = 32;

  typedef logic [RomAw-1:0] rom_addr_t;
  typedef logic [RomDw-1:0] rom_data_t;

  // Multi-bit boolean, only two legal codes
  typedef logic [3:0] mubi4_t;
  parameter mubi4_t MuBi4True  = 4'h6;
  parameter mubi4_t MuBi4False = 4'h9;

  function automatic logic mubi4_test_true_strict(mubi4_t val);
    return val == MuBi4True;
  endfunction

  function automatic logic mubi4_test_false_loose(mubi4_t val);
    return val != MuBi4True;
  endfunction

  function automatic logic mubi4_test_true_loose(mubi4_t val);
    return val != MuBi4False;
  endfunction

  function automatic logic mubi4_test_invalid(mubi4_t val);
    return (val != MuBi4True) && (val != MuBi4False);
  endfunction

  // Stand-in for the block cipher keystream
  parameter rom_data_t RomKey = 32'hA5C3_5A3C;

  function automatic rom_data_t rom_keystream(rom_addr_t addr);
    logic [RomAw*((RomDw+RomAw-1)/RomAw)-1:0] rep;
    rep = {((RomDw + RomAw - 1) / RomAw){addr}};
    return rep[RomDw-1:0] ^ RomKey;
  endfunction

  // Clear ROM content, golden-ratio hash of the address
  function automatic rom_data_t rom_clear_word(rom_addr_t addr);
    logic [31:0] prod;
    prod = 32'(addr) * 32'h9E37_79B1;
    return prod;
  endfunction

  // APB map, ROM window starts at 0
  parameter logic [31:0] ApbStatusAddr = 32'h1000;

endpackage

//--- design/rom_port_if.sv
// ----------------------------------------
// Mux-to-ROM and front-end-to-mux ports
// ----------------------------------------
`timescale 1ns/1ps

// ROM side, rvalid one cycle after req
interface rom_port_if;
  import rom_ctrl_pkg::*;

  rom_addr_t addr;
  logic      req;
  rom_data_t scr_rdata;
  rom_data_t clr_rdata;
  logic      rvalid;

  modport mux (output addr, req, input scr_rdata, clr_rdata, rvalid);
  modport rom (input addr, req, output scr_rdata, clr_rdata, rvalid);
endinterface

// Bus side, accepted on req and gnt
interface bus_port_if;
  import rom_ctrl_pkg::*;

  rom_addr_t addr;
  logic      req;
  logic      gnt;
  rom_data_t rdata;
  logic      rvalid;

  modport host (output addr, req, input gnt, rdata, rvalid);
  modport mux (input addr, req, output gnt, rdata, rvalid);
endinterface

//--- design/rom_ctrl_mux.sv
// ----------------------------------------
// One-way checker/bus mux with select alert
// ----------------------------------------
`timescale 1ns/1ps

module rom_ctrl_mux #(
  parameter int Aw = rom_ctrl_pkg::RomAw
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  rom_ctrl_pkg::mubi4_t    sel_bus_i,
  bus_port_if.mux                 bus,
  input  rom_ctrl_pkg::rom_addr_t chk_addr_i,
  input  logic                    chk_req_i,
  output rom_ctrl_pkg::rom_data_t chk_rdata_o,
  rom_port_if.mux                 rom,
  output logic                    alert_o
);
  import rom_ctrl_pkg::*;

  // Select history, q is one cycle old and qq two cycles old
  mubi4_t    sel_bus_q;
  mubi4_t    sel_bus_qq;
  logic      alert_q;
  logic      bus_sel;
  logic      sel_invalid;
  logic      sel_reverted;
  logic      sel_q_reverted;
  rom_addr_t mux_addr;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_bus_q  <= MuBi4False;
      sel_bus_qq <= MuBi4False;
    end else begin
      sel_bus_q  <= sel_bus_i;
      sel_bus_qq <= sel_bus_q;
    end
  end

  // Corrupt select code on the input or its copy
  assign sel_invalid = mubi4_test_invalid(sel_bus_i) || mubi4_test_invalid(sel_bus_q);

  // Bus handed back to the checker
  assign sel_reverted   = mubi4_test_true_loose(sel_bus_q) & mubi4_test_false_loose(sel_bus_i);
  assign sel_q_reverted = mubi4_test_true_loose(sel_bus_qq) & mubi4_test_false_loose(sel_bus_q);

  // Sticky, rises one cycle after the fault
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_q <= 1'b0;
    end else if (sel_invalid || sel_reverted || sel_q_reverted) begin
      alert_q <= 1'b1;
    end
  end

  assign alert_o = alert_q;

  // Bus owns the ROM only for a strictly True select
  assign bus_sel  = mubi4_test_true_strict(sel_bus_i);
  assign bus.gnt  = bus_sel;
  assign bus.rdata = rom.clr_rdata;
  // Response is for the bus if the select was True when requested
  assign bus.rvalid = mubi4_test_true_strict(sel_bus_q) & rom.rvalid;

  // Checker sees the scrambled word for its digest
  assign chk_rdata_o = rom.scr_rdata;

  // Address limited to the ROM depth
  assign mux_addr = bus_sel ? bus.addr : chk_addr_i;
  assign rom.addr = rom_addr_t'(mux_addr[Aw-1:0]);
  assign rom.req  = bus_sel ? bus.req : chk_req_i;

  // A grant once given is held for good
  a_gnt_one_way: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus.gnt |=> bus.gnt)
    else $error("gnt dropped after grant");

endmodule

//--- design/rom_ctrl_rom.sv
// ----------------------------------------
// Scrambled ROM with one-cycle read
// ----------------------------------------
`timescale 1ns/1ps

module rom_ctrl_rom #(
  parameter int Aw = rom_ctrl_pkg::RomAw
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  rom_port_if.rom port
);
  import rom_ctrl_pkg::*;

  localparam int Depth = 2 ** Aw;

  // XOR of every stored word below the last address
  function automatic rom_data_t calc_digest();
    rom_data_t acc;
    acc = '0;
    for (int i = 0; i < Depth - 1; i++) begin
      acc ^= rom_clear_word(rom_addr_t'(i)) ^ rom_keystream(rom_addr_t'(i));
    end
    return acc;
  endfunction

  localparam rom_data_t Digest = calc_digest();

  rom_data_t     mem [Depth];
  logic [Aw-1:0] idx;
  rom_data_t     scr_q;
  rom_data_t     clr_q;
  logic          rvalid_q;

  // Content fixed at elaboration, digest kept in clear at the top
  for (genvar i = 0; i < Depth; i++) begin : g_mem
    if (i == Depth - 1) begin : g_digest
      assign mem[i] = Digest;
    end else begin : g_word
      assign mem[i] = rom_clear_word(rom_addr_t'(i)) ^ rom_keystream(rom_addr_t'(i));
    end
  end

  assign idx = port.addr[Aw-1:0];

  // Read data registers, loaded on each request
  always_ff @(posedge clk_i) begin
    if (port.req) begin
      scr_q <= mem[idx];
      clr_q <= mem[idx] ^ rom_keystream(port.addr);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= port.req;
    end
  end

  assign port.scr_rdata = scr_q;
  assign port.clr_rdata = clr_q;
  assign port.rvalid    = rvalid_q;

  a_rvalid_follows_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    port.req |=> (port.rvalid && !$isunknown({port.scr_rdata, port.clr_rdata})))
    else $error("rvalid missing or read data unknown one cycle after req");

endmodule

//--- design/rom_ctrl_checker.sv
// ----------------------------------------
// ROM sweep, digest fold and comparison
// ----------------------------------------
`timescale 1ns/1ps

module rom_ctrl_checker #(
  parameter int Aw = rom_ctrl_pkg::RomAw
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    start_i,
  input  rom_ctrl_pkg::rom_data_t rdata_i,
  output rom_ctrl_pkg::rom_addr_t addr_o,
  output logic                    req_o,
  output logic                    done_o,
  output logic                    good_o
);
  import rom_ctrl_pkg::*;

  localparam logic [Aw-1:0] LastAddr = '1;

  logic [Aw-1:0] cnt_q;
  logic          busy_q;
  // Delayed request, marks cycles that carry read data
  logic          req_q;
  // Data in flight is the stored digest
  logic          last_q;
  logic          done_q;
  logic          good_q;
  rom_data_t     acc_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q  <= '0;
      busy_q <= 1'b0;
      req_q  <= 1'b0;
      last_q <= 1'b0;
      done_q <= 1'b0;
      good_q <= 1'b0;
    end else begin
      req_q  <= busy_q;
      last_q <= busy_q && (cnt_q == LastAddr);
      done_q <= req_q && last_q;
      if (start_i) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
        good_q <= 1'b0;
      end else if (busy_q) begin
        cnt_q <= cnt_q + 1'b1;
        // Sweep ends after the last address
        if (cnt_q == LastAddr) begin
          busy_q <= 1'b0;
        end
      end
      // Compare the fold with the stored digest
      if (req_q && last_q) begin
        good_q <= (acc_q == rdata_i);
      end
    end
  end

  // Digest fold over scrambled words
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      acc_q <= '0;
    end else if (req_q && !last_q) begin
      acc_q <= acc_q ^ rdata_i;
    end
  end

  assign addr_o = rom_addr_t'(cnt_q);
  assign req_o  = busy_q;
  assign done_o = done_q;
  assign good_o = good_q;

endmodule

//--- design/rom_ctrl_fsm.sv
// ----------------------------------------
// Check sequencing and bus select FSM
// ----------------------------------------
`timescale 1ns/1ps

module rom_ctrl_fsm (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 chk_done_i,
  input  logic                 chk_good_i,
  output logic                 chk_start_o,
  output rom_ctrl_pkg::mubi4_t sel_bus_o,
  output logic                 done_o,
  output logic                 good_o
);
  import rom_ctrl_pkg::*;

  typedef enum logic [1:0] {
    StIdle,
    StCheck,
    StDone
  } state_e;

  state_e state_q;
  logic   start_q;
  logic   good_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StIdle;
      start_q <= 1'b0;
      good_q  <= 1'b0;
    end else begin
      // One-cycle start pulse on leaving Idle
      start_q <= (state_q == StIdle);
      case (state_q)
        StIdle: state_q <= StCheck;
        StCheck: begin
          if (chk_done_i) begin
            state_q <= StDone;
            good_q  <= chk_good_i;
          end
        end
        // Terminal, the bus keeps the ROM
        default: state_q <= StDone;
      endcase
    end
  end

  assign chk_start_o = start_q;
  // Decoded from state only, cannot fall back to False
  assign sel_bus_o   = (state_q == StDone) ? MuBi4True : MuBi4False;
  assign done_o      = (state_q == StDone);
  assign good_o      = good_q;

  a_sel_stays_true: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (sel_bus_o == MuBi4True) |=> (sel_bus_o == MuBi4True))
    else $error("sel_bus left True after Done");

endmodule

//--- design/rom_ctrl_apb.sv
// ----------------------------------------
// APB slave for ROM window and status
// ----------------------------------------
`timescale 1ns/1ps

module rom_ctrl_apb #(
  parameter int Aw = rom_ctrl_pkg::RomAw
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [31:0] paddr_i,
  input  logic [31:0] pwdata_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o,
  bus_port_if.host    bus,
  input  logic        done_i,
  input  logic        good_i,
  input  logic        alert_i
);
  import rom_ctrl_pkg::*;

  logic        access;
  logic        rom_hit;
  logic        stat_hit;
  logic        rd_rom;
  logic        err;
  // Read accepted, waiting for rvalid
  logic        pend_q;
  logic [31:0] status;

  assign access   = psel_i && penable_i;
  // ROM window is 4 bytes per word from address 0
  assign rom_hit  = paddr_i < (32'd4 << Aw);
  assign stat_hit = (paddr_i == ApbStatusAddr);
  assign rd_rom   = access && !pwrite_i && rom_hit;
  // Read-only slave, writes and holes are errors
  assign err      = access && (pwrite_i || !(rom_hit || stat_hit));

  // Held until granted, once per transfer
  assign bus.req  = rd_rom && !pend_q;
  assign bus.addr = rom_addr_t'(paddr_i[Aw+1:2]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q <= 1'b0;
    end else if (bus.req && bus.gnt) begin
      pend_q <= 1'b1;
    end else if (bus.rvalid) begin
      pend_q <= 1'b0;
    end
  end

  assign status = {29'd0, alert_i, good_i, done_i};

  // Status and errors finish at once, ROM reads on rvalid
  assign pready_o  = err || (access && !pwrite_i && stat_hit) || (pend_q && bus.rvalid);
  assign pslverr_o = err;
  assign prdata_o  = stat_hit ? status : bus.rdata;

  a_wdata_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (access && pwrite_i) |-> !$isunknown(pwdata_i))
    else $error("pwdata unknown during write access");

endmodule

//--- design/rom_ctrl_top.sv
// ----------------------------------------
// ROM controller top with APB and alert
// ----------------------------------------
`timescale 1ns/1ps

module rom_ctrl_top #(
  parameter int Aw = rom_ctrl_pkg::RomAw
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [31:0] paddr_i,
  input  logic [31:0] pwdata_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o,
  output logic        alert_o
);
  import rom_ctrl_pkg::*;

  rom_addr_t chk_addr;
  logic      chk_req;
  rom_data_t chk_rdata;
  logic      chk_start;
  logic      chk_done;
  logic      chk_good;
  mubi4_t    sel_bus;
  logic      done;
  logic      good;

  rom_port_if u_rom_port ();
  bus_port_if u_bus_port ();

  rom_ctrl_fsm u_fsm (
    .clk_i, .rst_ni, .chk_done_i(chk_done), .chk_good_i(chk_good),
    .chk_start_o(chk_start), .sel_bus_o(sel_bus), .done_o(done), .good_o(good)
  );

  rom_ctrl_checker #(.Aw(Aw)) u_checker (
    .clk_i, .rst_ni, .start_i(chk_start), .rdata_i(chk_rdata),
    .addr_o(chk_addr), .req_o(chk_req), .done_o(chk_done), .good_o(chk_good)
  );

  // Alert also feeds the status register
  rom_ctrl_mux #(.Aw(Aw)) u_mux (
    .clk_i, .rst_ni, .sel_bus_i(sel_bus), .bus(u_bus_port.mux),
    .chk_addr_i(chk_addr), .chk_req_i(chk_req), .chk_rdata_o(chk_rdata),
    .rom(u_rom_port.mux), .alert_o(alert_o)
  );

  rom_ctrl_rom #(.Aw(Aw)) u_rom (.clk_i, .rst_ni, .port(u_rom_port.rom));

  rom_ctrl_apb #(.Aw(Aw)) u_apb (
    .clk_i, .rst_ni, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o, .bus(u_bus_port.host),
    .done_i(done), .good_i(good), .alert_i(alert_o)
  );

endmodule

//--- tb/rom_ctrl_tb.sv
// ----------------------------------------
// Random APB testbench with ROM reference model
// ----------------------------------------
`timescale 1ns/1ps

module rom_ctrl_tb;
  import rom_ctrl_pkg::*;

  localparam int Aw = RomAw;
  localparam int Depth = 2 ** Aw;
  localparam int Transfers = 200;
  localparam int BurstLen = 8;
  // Ten cycles per transfer plus the integrity check and margin
  localparam int Limit = (Transfers + BurstLen) * 10 + Depth + 100;

  logic        clk_i;
  logic        rst_ni;
  logic        psel_i;
  logic        penable_i;
  logic        pwrite_i;
  logic [31:0] paddr_i;
  logic [31:0] pwdata_i;
  logic [31:0] prdata_o;
  logic        pready_o;
  logic        pslverr_o;
  logic        alert_o;

  int          errors = 0;
  int          cyc = 0;
  int          rel_cyc = 0;
  logic        timed_out = 1'b0;
  // Set once the first ROM read got through the check
  logic        bus_open = 1'b0;
  logic [31:0] digest;

  rom_ctrl_top #(.Aw(Aw)) u_rom_ctrl_top (
    .clk_i, .rst_ni, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o, .alert_o
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cyc <= cyc + 1;

  // Keystream, address bits repeated over the word
  function automatic logic [31:0] scramble_key(logic [31:0] a);
    logic [31:0] ks;
    for (int i = 0; i < 32; i++) begin
      ks[i] = a[i % Aw];
    end
    return ks ^ RomKey;
  endfunction

  function automatic logic [31:0] expected_clear(logic [31:0] a);
    return a * 32'h9E37_79B1;
  endfunction

  task automatic end_run();
    $display("Run finished with %0d errors, timeout %0d", errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  // Setup then access, returns at the negedge where pready is seen
  task automatic apb_transfer(input logic wr, input logic [31:0] addr,
                              output logic [31:0] rdata, output logic err, output int waits);
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= wr;
    paddr_i   <= addr;
    pwdata_i  <= $urandom;
    @(posedge clk_i);
    penable_i <= 1'b1;
    waits = 0;
    do begin
      @(negedge clk_i);
      waits++;
    end while (!pready_o);
    rdata = prdata_o;
    err   = pslverr_o;
  endtask

  task automatic rom_read(input int word);
    logic [31:0] rdata;
    logic [31:0] exp;
    logic        err;
    int          waits;
    apb_transfer(1'b0, 32'(word) << 2, rdata, err, waits);
    // Digest word comes back as digest XOR keystream
    exp = (word == Depth - 1) ? (digest ^ scramble_key(word)) : expected_clear(word);
    assert (rdata == exp) else begin
      errors++;
      $display("FAIL prdata at word %h: got %h expected %h", word, rdata, exp);
    end
    assert (err == 1'b0) else begin
      errors++;
      $display("FAIL pslverr on ROM read: got %h expected 0", err);
    end
    if (!bus_open) begin
      assert (cyc - rel_cyc >= Depth + 2) else begin
        errors++;
        $display("First ROM read finished %0d cycles after reset, before the check", cyc - rel_cyc);
      end
      bus_open = 1'b1;
    end else begin
      assert (waits == 2) else begin
        errors++;
        $display("ROM read took %0d access cycles instead of 2", waits);
      end
    end
  endtask

  task automatic status_read();
    logic [31:0] rdata;
    logic        err;
    int          waits;
    apb_transfer(1'b0, ApbStatusAddr, rdata, err, waits);
    assert (rdata == 32'h3 && rdata[2] == alert_o && err == 1'b0 && waits == 1) else begin
      errors++;
      $display("FAIL status prdata: got %h expected %h, pslverr %h, alert_o %h, waits %0d",
               rdata, 32'h3, err, alert_o, waits);
    end
  endtask

  task automatic error_access(input logic wr, input logic [31:0] addr);
    logic [31:0] rdata;
    logic        err;
    int          waits;
    apb_transfer(wr, addr, rdata, err, waits);
    assert (err == 1'b1 && waits == 1) else begin
      errors++;
      $display("FAIL pslverr at %h: got %h expected 1 after %0d cycles", addr, err, waits);
    end
  endtask

  // Alert must never rise in a fault-free run
  initial begin
    forever begin
      @(negedge clk_i);
      assert (!rst_ni || alert_o == 1'b0) else begin
        errors++;
        $display("FAIL alert_o: got %h expected 0", alert_o);
      end
    end
  end

  initial begin
    wait (cyc >= Limit);
    $display("Timeout, run still busy after %0d cycles", Limit);
    timed_out = 1'b1;
    end_run();
  end

  initial begin
    int r;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    rst_ni    = 1'b0;
    void'($urandom(32'had9));
    // Digest over the scrambled words below the last address
    digest = '0;
    for (int i = 0; i < Depth - 1; i++) begin
      digest ^= expected_clear(i) ^ scramble_key(i);
    end
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    rel_cyc = cyc;
    // First transfer waits behind the integrity check
    rom_read($urandom % Depth);
    for (int n = 1; n < Transfers; n++) begin
      r = $urandom % 100;
      if (r < 70) begin
        rom_read($urandom % Depth);
      end else if (r < 85) begin
        status_read();
      end else if (r < 95) begin
        error_access(1'b1, $urandom & 32'h0000_1FFC);
      end else begin
        error_access(1'b0, ApbStatusAddr + 32'd4 + (($urandom % 256) << 2));
      end
    end
    // Back-to-back reads ending on the digest word
    for (int n = BurstLen; n > 0; n--) begin
      rom_read(Depth - n);
    end
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    end_run();
  end

endmodule

//--- flist.f
design/rom_ctrl_pkg.sv
design/rom_port_if.sv
design/rom_ctrl_mux.sv
design/rom_ctrl_rom.sv
design/rom_ctrl_checker.sv
design/rom_ctrl_fsm.sv
design/rom_ctrl_apb.sv
design/rom_ctrl_top.sv
tb/rom_ctrl_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module rom_ctrl_tb -o rom_ctrl_sim
out=$(./obj_dir/rom_ctrl_sim)
echo "$out"

if grep -qx "All checks passed" <<< "$out"; then
  exit 0
fi
exit 1
